// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_dma_frontend
FLIST     := compile.f

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'No errors'

clean:
	rm -rf obj_dir

// File: compile.f
dma_pkg.sv
dma_frontend_regs.sv
dma_transfer_id.sv
dma_copy_engine.sv
dma_dispatch.sv
dma_frontend.sv
tb_dma_frontend.sv

// File: dma_copy_engine.sv
////////////////////////////////////////////////////////////////////////////
// Word copy backend. Reads one word from the source, writes it to the
// destination on the next cycle and repeats for the whole length. The
// memory port has no stall and returns read data one cycle later.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dma_copy_engine (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                start_i,
    input  dma_pkg::dma_descr_t descr_i,
    output logic                idle_o,
    output logic                done_o,
    output dma_pkg::mem_req_t   mem_req_o,
    input  logic [31:0]         mem_rdata_i
);

    import dma_pkg::*;

    typedef enum logic [1:0] {
        StIdle,
        StRead,
        StWrite
    } state_e;

    state_e      state_q;
    logic        done_q;
    logic [31:0] src_q;
    logic [31:0] dst_q;
    logic [29:0] words_q;
    logic [29:0] start_words;
    logic        last_write;

    // length rounded down to whole words
    assign start_words = descr_i.num_bytes[31:2];
    assign last_write  = (state_q == StWrite) && (words_q == 30'd1);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= StIdle;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                StIdle: begin
                    if (start_i) begin
                        if (start_words == '0) begin
                            // nothing to copy, finish right away
                            done_q <= 1'b1;
                        end else begin
                            state_q <= StRead;
                        end
                    end
                end
                StRead: begin
                    state_q <= StWrite;
                end
                StWrite: begin
                    if (last_write) begin
                        state_q <= StIdle;
                        done_q  <= 1'b1;
                    end else begin
                        state_q <= StRead;
                    end
                end
                default: state_q <= StIdle;
            endcase
        end
    end

    // pointers and word count
    always_ff @(posedge clk_i) begin
        if (state_q == StIdle && start_i) begin
            src_q   <= descr_i.src_addr;
            dst_q   <= descr_i.dst_addr;
            words_q <= start_words;
        end else if (state_q == StRead) begin
            src_q <= src_q + 32'd4;
        end else if (state_q == StWrite) begin
            dst_q   <= dst_q + 32'd4;
            words_q <= words_q - 1'b1;
        end
    end

    always_comb begin
        mem_req_o.req   = (state_q == StRead) || (state_q == StWrite);
        mem_req_o.we    = (state_q == StWrite);
        mem_req_o.addr  = (state_q == StWrite) ? dst_q : src_q;
        // read data of the previous cycle goes straight back out
        mem_req_o.wdata = (state_q == StWrite) ? mem_rdata_i : '0;
    end

    assign idle_o = (state_q == StIdle);
    assign done_o = done_q;

endmodule

// File: dma_dispatch.sv
////////////////////////////////////////////////////////////////////////////
// Central dispatcher. Picks one pending register set round-robin while the
// copy engine is idle, hands its descriptor over and starts the engine.
// Also drives the busy flag and the completion events.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dma_dispatch (
    input  logic                                          clk_i,
    input  logic                                          rst_ni,
    input  logic [dma_pkg::NumRegs-1:0]                   pending_i,
    input  dma_pkg::dma_descr_t [dma_pkg::NumRegs-1:0]    descr_i,
    output logic [dma_pkg::NumRegs-1:0]                   take_o,
    output logic                                          start_o,
    output dma_pkg::dma_descr_t                           descr_o,
    input  logic                                          engine_idle_i,
    input  logic                                          engine_done_i,
    output logic                                          busy_o,
    output logic [dma_pkg::NumRegs-1:0]                   event_o
);

    import dma_pkg::*;

    logic [IdxWidth-1:0] rr_q;
    logic [IdxWidth-1:0] winner_idx;
    logic                winner_vld;

    // first pending set at or after the pointer, wrapping around
    always_comb begin : proc_select
        int unsigned cand;
        winner_vld = 1'b0;
        winner_idx = '0;
        for (int unsigned k = 0; k < NumRegs; k++) begin
            cand = rr_q + k;
            if (cand >= NumRegs) begin
                cand = cand - NumRegs;
            end
            if (!winner_vld && pending_i[cand]) begin
                winner_vld = 1'b1;
                winner_idx = IdxWidth'(cand);
            end
        end
    end

    // engine idle is the only back-pressure
    assign start_o = winner_vld && engine_idle_i;
    assign descr_o = descr_i[winner_idx];

    always_comb begin
        take_o = '0;
        if (start_o) begin
            take_o[winner_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rr_q <= '0;
        end else if (start_o) begin
            rr_q <= (winner_idx == IdxWidth'(NumRegs - 1)) ? '0 : winner_idx + 1'b1;
        end
    end

    assign busy_o  = !engine_idle_i;
    // every requester sees every completion
    assign event_o = {NumRegs{engine_done_i}};

endmodule

// File: dma_frontend.sv
////////////////////////////////////////////////////////////////////////////
// Cluster DMA frontend top. One register set per core plus one for the
// peripheral port, a round-robin dispatcher, the transfer id counters and
// a single word copy engine on a simple 32-bit memory port.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dma_frontend (
    input  logic                                        clk_i,
    input  logic                                        rst_ni,
    input  dma_pkg::ctrl_req_t [dma_pkg::NumCores-1:0]  core_req_i,
    output dma_pkg::ctrl_rsp_t [dma_pkg::NumCores-1:0]  core_rsp_o,
    input  dma_pkg::ctrl_req_t                          pe_req_i,
    input  logic [dma_pkg::PerifIdWidth-1:0]            pe_id_i,
    output dma_pkg::ctrl_rsp_t                          pe_rsp_o,
    output logic [dma_pkg::PerifIdWidth-1:0]            pe_r_id_o,
    output dma_pkg::mem_req_t                           mem_req_o,
    input  logic [31:0]                                 mem_rdata_i,
    output logic                                        busy_o,
    output logic [dma_pkg::NumRegs-1:0]                 event_o
);

    import dma_pkg::*;

    ctrl_req_t [NumRegs-1:0]  set_req;
    ctrl_rsp_t [NumRegs-1:0]  set_rsp;
    dma_descr_t [NumRegs-1:0] set_descr;
    logic [NumRegs-1:0]       set_pending;
    logic [NumRegs-1:0]       set_take;
    dma_descr_t               eng_descr;
    logic                     eng_start;
    logic                     eng_idle;
    logic                     eng_done;
    logic [TidWidth-1:0]      next_id;
    logic [TidWidth-1:0]      done_id;
    logic [PerifIdWidth-1:0]  pe_id_q;

    // peripheral owns the last set
    assign set_req    = {pe_req_i, core_req_i};
    assign core_rsp_o = set_rsp[NumCores-1:0];
    assign pe_rsp_o   = set_rsp[NumCores];

    for (genvar i = 0; i < NumRegs; i++) begin : gen_regs
        dma_frontend_regs i_regs (
            .clk_i     ( clk_i          ),
            .rst_ni    ( rst_ni         ),
            .req_i     ( set_req[i]     ),
            .rsp_o     ( set_rsp[i]     ),
            .next_id_i ( next_id        ),
            .done_id_i ( done_id        ),
            .take_i    ( set_take[i]    ),
            .pending_o ( set_pending[i] ),
            .descr_o   ( set_descr[i]   )
        );
    end

    dma_dispatch i_dispatch (
        .clk_i         ( clk_i       ),
        .rst_ni        ( rst_ni      ),
        .pending_i     ( set_pending ),
        .descr_i       ( set_descr   ),
        .take_o        ( set_take    ),
        .start_o       ( eng_start   ),
        .descr_o       ( eng_descr   ),
        .engine_idle_i ( eng_idle    ),
        .engine_done_i ( eng_done    ),
        .busy_o        ( busy_o      ),
        .event_o       ( event_o     )
    );

    dma_transfer_id i_transfer_id (
        .clk_i       ( clk_i     ),
        .rst_ni      ( rst_ni    ),
        .issue_i     ( eng_start ),
        .retire_i    ( eng_done  ),
        .next_o      ( next_id   ),
        .completed_o ( done_id   )
    );

    dma_copy_engine i_copy_engine (
        .clk_i       ( clk_i       ),
        .rst_ni      ( rst_ni      ),
        .start_i     ( eng_start   ),
        .descr_i     ( eng_descr   ),
        .idle_o      ( eng_idle    ),
        .done_o      ( eng_done    ),
        .mem_req_o   ( mem_req_o   ),
        .mem_rdata_i ( mem_rdata_i )
    );

    // response comes a cycle after the grant, so the id follows one cycle late
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pe_id_q <= '0;
        end else begin
            pe_id_q <= pe_id_i;
        end
    end

    assign pe_r_id_o = pe_id_q;

endmodule

// File: dma_frontend_regs.sv
////////////////////////////////////////////////////////////////////////////
// Register set of one requester. Decodes target accesses, holds the
// descriptor and raises a pending request towards the dispatcher on a
// launch read. The launch grant is held back until the set is taken.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dma_frontend_regs (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  dma_pkg::ctrl_req_t              req_i,
    output dma_pkg::ctrl_rsp_t              rsp_o,
    input  logic [dma_pkg::TidWidth-1:0]    next_id_i,
    input  logic [dma_pkg::TidWidth-1:0]    done_id_i,
    input  logic                            take_i,
    output logic                            pending_o,
    output dma_pkg::dma_descr_t             descr_o
);

    import dma_pkg::*;

    logic [2:0]  offset;
    logic        is_launch;
    logic        gnt;
    logic        rd_gnt;
    logic        wr_gnt;
    logic [31:0] rdata_d;
    logic        pending_q;
    logic        rvalid_q;
    logic [31:0] rdata_q;
    dma_descr_t  descr_q;

    function automatic logic [31:0] be_merge(logic [31:0] old_w, logic [31:0] new_w,
                                             logic [3:0] be);
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    assign offset    = req_i.addr[4:2];
    assign is_launch = req_i.req && !req_i.we && (offset == RegLaunch);

    // writes and plain reads go through at once, launch waits for take
    assign gnt    = req_i.req && (is_launch ? take_i : 1'b1);
    assign rd_gnt = gnt && !req_i.we;
    assign wr_gnt = gnt && req_i.we;

    always_comb begin
        case (offset)
            RegSrc:    rdata_d = descr_q.src_addr;
            RegDst:    rdata_d = descr_q.dst_addr;
            RegLen:    rdata_d = descr_q.num_bytes;
            // id handed out at the take
            RegLaunch: rdata_d = {{(32-TidWidth){1'b0}}, next_id_i};
            RegStatus: rdata_d = {{(32-TidWidth){1'b0}}, done_id_i};
            default:   rdata_d = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pending_q <= 1'b0;
            rvalid_q  <= 1'b0;
        end else begin
            rvalid_q <= rd_gnt;
            if (take_i) begin
                pending_q <= 1'b0;
            end else if (is_launch) begin
                pending_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_gnt) begin
            rdata_q <= rdata_d;
        end
        if (wr_gnt) begin
            case (offset)
                RegSrc:  descr_q.src_addr  <= be_merge(descr_q.src_addr, req_i.wdata, req_i.be);
                RegDst:  descr_q.dst_addr  <= be_merge(descr_q.dst_addr, req_i.wdata, req_i.be);
                RegLen:  descr_q.num_bytes <= be_merge(descr_q.num_bytes, req_i.wdata, req_i.be);
                default: ;
            endcase
        end
    end

    assign rsp_o.gnt     = gnt;
    assign rsp_o.r_valid = rvalid_q;
    assign rsp_o.r_data  = rdata_q;
    assign pending_o     = pending_q;
    assign descr_o       = descr_q;

endmodule

// File: dma_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared sizes, register map and bundle types of the cluster DMA frontend.
// Modules import it with a wildcard in their body and use scoped names in
// their port lists.
////////////////////////////////////////////////////////////////////////////

package dma_pkg;

    // four cores plus one peripheral register set
    localparam int unsigned NumCores     = 4;
    localparam int unsigned NumRegs      = NumCores + 1;
    localparam int unsigned IdxWidth     = $clog2(NumRegs);
    localparam int unsigned TidWidth     = 28;
    localparam int unsigned PerifIdWidth = 8;

    // word offsets, taken from address bits 4:2
    localparam logic [2:0] RegSrc    = 3'd0;
    localparam logic [2:0] RegDst    = 3'd1;
    localparam logic [2:0] RegLen    = 3'd2;
    localparam logic [2:0] RegLaunch = 3'd3;
    localparam logic [2:0] RegStatus = 3'd4;

    typedef struct packed {
        logic [31:0] num_bytes;
        logic [31:0] dst_addr;
        logic [31:0] src_addr;
    } dma_descr_t;

    // target request with we set for a write
    typedef struct packed {
        logic        req;
        logic        we;
        logic [3:0]  be;
        logic [31:0] addr;
        logic [31:0] wdata;
    } ctrl_req_t;

    typedef struct packed {
        logic        gnt;
        logic        r_valid;
        logic [31:0] r_data;
    } ctrl_rsp_t;

    typedef struct packed {
        logic        req;
        logic        we;
        logic [31:0] addr;
        logic [31:0] wdata;
    } mem_req_t;

endpackage

// File: dma_transfer_id.sv
////////////////////////////////////////////////////////////////////////////
// Transfer id bookkeeping. next_o is the id of the next issued transfer,
// completed_o counts retired transfers. Both wrap.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dma_transfer_id (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         issue_i,
    input  logic                         retire_i,
    output logic [dma_pkg::TidWidth-1:0] next_o,
    output logic [dma_pkg::TidWidth-1:0] completed_o
);

    logic [dma_pkg::TidWidth-1:0] next_q;
    logic [dma_pkg::TidWidth-1:0] done_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            next_q <= '0;
            done_q <= '0;
        end else begin
            if (issue_i) begin
                next_q <= next_q + 1'b1;
            end
            if (retire_i) begin
                done_q <= done_q + 1'b1;
            end
        end
    end

    assign next_o      = next_q;
    assign completed_o = done_q;

endmodule

// File: tb_dma_frontend.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the cluster DMA frontend. Programs transfers through the
// core and peripheral target ports, models the word memory and checks the
// copies against a shadow memory updated by a reference copy function.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_dma_frontend;

    import dma_pkg::*;

    localparam int MemWords = 256;
    localparam int Timeout  = 400;

    logic                     clk = 1'b0;
    logic                     rst_n;
    ctrl_req_t [NumCores-1:0] core_req;
    ctrl_rsp_t [NumCores-1:0] core_rsp;
    ctrl_req_t                pe_req;
    ctrl_rsp_t                pe_rsp;
    logic [PerifIdWidth-1:0]  pe_id;
    logic [PerifIdWidth-1:0]  pe_r_id;
    mem_req_t                 mem_req;
    mem_req_t                 mem_cmd = '0;
    logic [31:0]              mem_rdata;
    logic                     busy;
    logic [NumRegs-1:0]       events;

    logic [31:0]             mem [MemWords];
    logic [31:0]             shadow [MemWords];
    logic [PerifIdWidth-1:0] pe_tag = '0;
    logic [PerifIdWidth-1:0] pe_last_rid;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int test_errors = 0;
    int ev_count = 0;
    int wr_count = 0;
    int exp_id = 0;

    dma_frontend dut_i (
        .clk_i       ( clk       ),
        .rst_ni      ( rst_n     ),
        .core_req_i  ( core_req  ),
        .core_rsp_o  ( core_rsp  ),
        .pe_req_i    ( pe_req    ),
        .pe_id_i     ( pe_id     ),
        .pe_rsp_o    ( pe_rsp    ),
        .pe_r_id_o   ( pe_r_id   ),
        .mem_req_o   ( mem_req   ),
        .mem_rdata_i ( mem_rdata ),
        .busy_o      ( busy      ),
        .event_o     ( events    )
    );

    always #20 clk = ~clk;

    // memory answers the request of the previous cycle
    always @(posedge clk) begin
        #5;
        if (mem_cmd.req && mem_cmd.we) begin
            mem[mem_cmd.addr[9:2]] = mem_cmd.wdata;
        end else if (mem_cmd.req) begin
            mem_rdata = mem[mem_cmd.addr[9:2]];
        end
    end

    // sample requests and events mid-cycle
    always @(negedge clk) begin
        mem_cmd = mem_req;
        if (mem_req.req && mem_req.we) begin
            wr_count++;
        end
        if (events !== '0) begin
            ev_count++;
            checks++;
            assert (events === '1)
            else begin
                $display("mismatch event_o: got %h, expected %h", events, {NumRegs{1'b1}});
                errors++;
            end
        end
    end

    function automatic void ref_copy(logic [31:0] src, logic [31:0] dst, logic [31:0] nbytes);
        for (int w = 0; w < int'(nbytes >> 2); w++) begin
            shadow[dst[9:2] + w] = shadow[src[9:2] + w];
        end
    endfunction

    function automatic ctrl_rsp_t rsp_of(int p);
        if (p == NumCores) begin
            return pe_rsp;
        end
        return core_rsp[p];
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("Errors found");
        $finish;
    endtask

    task automatic drive(input int p, input ctrl_req_t r);
        if (p == NumCores) begin
            pe_req = r;
            pe_id  = r.req ? pe_tag : '0;
        end else begin
            core_req[p] = r;
        end
    endtask

    // one target access with req held until granted
    task automatic access(input int p, input logic we, input logic [2:0] off,
                          input logic [31:0] wdata, input logic [3:0] be,
                          output logic [31:0] rdata);
        ctrl_req_t r;
        ctrl_rsp_t s;
        int        cycles;
        r = '{req: 1'b1, we: we, be: be, addr: {27'd0, off, 2'b00}, wdata: wdata};
        @(posedge clk);
        #5;
        drive(p, r);
        cycles = 0;
        @(negedge clk);
        s = rsp_of(p);
        while (!s.gnt && cycles < Timeout) begin
            @(negedge clk);
            s = rsp_of(p);
            cycles++;
        end
        if (!s.gnt) begin
            stop_on_timeout("target grant");
        end
        @(posedge clk);
        #5;
        drive(p, '0);
        @(negedge clk);
        s = rsp_of(p);
        check_val("r_valid", s.r_valid, !we);
        rdata = s.r_data;
        if (p == NumCores) begin
            pe_last_rid = pe_r_id;
        end
    endtask

    task automatic setup_copy(input int p, input int slot);
        logic [31:0] src;
        logic [31:0] dst;
        logic [31:0] nbytes;
        logic [31:0] rd;
        src    = (32 * slot + $urandom % 8) * 4;
        dst    = (160 + 16 * slot + $urandom % 8) * 4;
        nbytes = (1 + $urandom % 8) * 4 + $urandom % 4;
        access(p, 1'b1, RegSrc, src, 4'hf, rd);
        access(p, 1'b1, RegDst, dst, 4'hf, rd);
        access(p, 1'b1, RegLen, nbytes, 4'hf, rd);
        ref_copy(src, dst, nbytes);
    endtask

    task automatic launch(input int p);
        logic [31:0] rd;
        access(p, 1'b0, RegLaunch, '0, 4'h0, rd);
        check_val("launch id", rd, exp_id);
        exp_id++;
    endtask

    task automatic check_status(input int p);
        logic [31:0] rd;
        access(p, 1'b0, RegStatus, '0, 4'h0, rd);
        check_val("status", rd, exp_id);
    endtask

    // event count moves at the falling edge, so poll it on the rising one
    task automatic wait_events(input int target);
        int cycles;
        cycles = 0;
        while (ev_count < target && cycles < Timeout) begin
            @(posedge clk);
            cycles++;
        end
        if (ev_count < target) begin
            stop_on_timeout("completion event");
        end
        @(negedge clk);
    endtask

    task automatic compare_memory();
        for (int i = 0; i < MemWords; i++) begin
            check_val($sformatf("mem[%0h]", i * 4), mem[i], shadow[i]);
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s: %s (%0d errors)", name,
                 (errors == test_errors) ? "ok" : "FAILED", errors - test_errors);
        test_errors = errors;
        tests++;
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] ids [NumRegs];
        bit          seen [NumRegs];
        int          idx;
        int          wr_before;
        void'($urandom(32'h3d7a_7971));
        rst_n     = 1'b0;
        core_req  = '0;
        pe_req    = '0;
        pe_id     = '0;
        mem_rdata = '0;
        for (int i = 0; i < MemWords; i++) begin
            mem[i]    = $urandom;
            shadow[i] = mem[i];
        end
        repeat (4) @(posedge clk);
        #5;
        rst_n = 1'b1;

        setup_copy(0, 0);
        launch(0);
        wait_events(exp_id);
        compare_memory();
        end_test("single copy");

        setup_copy(1, 1);
        launch(1);
        wait_events(exp_id);
        setup_copy(1, 2);
        launch(1);
        wait_events(exp_id);
        check_status(1);
        compare_memory();
        end_test("consecutive ids");

        // all sets launch together and the dispatcher serializes them
        pe_tag = 8'h5a;
        for (int p = 0; p < NumRegs; p++) begin
            setup_copy(p, p);
            seen[p] = 1'b0;
        end
        for (int p = 0; p < NumRegs; p++) begin
            fork
                automatic int q = p;
                access(q, 1'b0, RegLaunch, '0, 4'h0, ids[q]);
            join_none
        end
        wait fork;
        for (int p = 0; p < NumRegs; p++) begin
            idx = int'(ids[p]) - exp_id;
            checks++;
            assert (idx >= 0 && idx < int'(NumRegs) && !seen[idx])
            else begin
                $display("mismatch launch id of set %0d: got %h, expected a new id from %h to %h",
                         p, ids[p], exp_id, exp_id + int'(NumRegs) - 1);
                errors++;
            end
            if (idx >= 0 && idx < int'(NumRegs)) begin
                seen[idx] = 1'b1;
            end
        end
        exp_id += NumRegs;
        wait_events(exp_id);
        compare_memory();
        end_test("concurrent launch");

        pe_tag = 8'($urandom);
        check_status(NumCores);
        check_val("pe_r_id_o", pe_last_rid, pe_tag);
        end_test("peripheral id");

        setup_copy(2, 3);
        launch(2);
        check_val("busy_o", busy, 1'b1);
        wait_events(exp_id);
        check_val("busy_o", busy, 1'b0);
        check_val("event pulses", ev_count, exp_id);
        compare_memory();
        end_test("busy and events");

        access(3, 1'b1, RegSrc, 32'h1122_3344, 4'hf, rd);
        access(3, 1'b1, RegSrc, 32'haabb_ccdd, 4'b0101, rd);
        access(3, 1'b0, RegSrc, '0, 4'h0, rd);
        check_val("src register", rd, 32'h11bb_33dd);
        access(3, 1'b1, RegLen, '0, 4'hf, rd);
        wr_before = wr_count;
        launch(3);
        wait_events(exp_id);
        check_val("memory writes", wr_count - wr_before, 0);
        check_status(3);
        compare_memory();
        end_test("byte enables and zero length");

        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
